/* flist.f */
+incdir+design
design/cache_types_pkg.sv
design/mem_bus_pkg.sv
design/llsc_reservation.sv
design/dcache_array.sv
design/dcache_ctrl.sv
design/dcache.sv
test/mem_model.sv
test/tb_dcache.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f flist.f --top-module tb_dcache -o tb_dcache_sim \
        && ./obj_dir/tb_dcache_sim > sim.log 2>&1

cat sim.log 2> /dev/null

! grep -q "Regression failed" sim.log && grep -q "Regression passed" sim.log \
        && echo "Simulation PASS" \
        || { echo "Simulation FAIL"; exit 1; }

/* test/tb_dcache.sv */
`include "dcache_consts.svh"
`default_nettype none

module tb_dcache
        import mem_bus_pkg::*;
();

        timeunit 1ns;
        timeprecision 100ps;

        localparam int N_SLOTS = 48;
        localparam int N_OPS = 400;
        // About 20 cycles per access at worst, slack covers LL/SC groups and the flush
        localparam int MAX_CYCLES = N_OPS * 50;

        logic     CLK;
        logic     nRST;
        dp_req_t  dp_req;
        dp_rsp_t  dp_rsp;
        mem_req_t mem_req;
        word_t    dload;
        logic     dwait;
        word_t    peek_addr;
        word_t    peek_data;

        word_t    ref_mem [N_SLOTS];
        logic     started;
        logic     flushed_seen;
        logic     link_valid;
        int       link_slot;
        int       cycles = 0;

        dcache DUT (
                .CLK     (CLK),
                .nRST    (nRST),
                .dp_req  (dp_req),
                .dp_rsp  (dp_rsp),
                .mem_req (mem_req),
                .dload   (dload),
                .dwait   (dwait)
        );

        mem_model mem (
                .CLK       (CLK),
                .nRST      (nRST),
                .mem_req   (mem_req),
                .dload     (dload),
                .dwait     (dwait),
                .peek_addr (peek_addr),
                .peek_data (peek_data)
        );

        initial begin
                CLK = 1'b0;
                forever begin
                        #10 CLK = ~CLK;
                end
        end

        task automatic stop_on_error(input string what);
                $display("%s", what);
                $display("Regression failed");
                $fatal(1);
        endtask

        task automatic value_error(input string name, input word_t exp, input word_t act);
                stop_on_error($sformatf("ERROR at %0d ns: %s expected %h, got %h",
                                        $time, name, exp, act));
        endtask

        task automatic check_word(input string name, input word_t exp, input word_t act);
                assert (act === exp)
                else value_error(name, exp, act);
        endtask

        // 24 blocks, three per set, two words each
        function automatic word_t slot_addr(input int slot);
                return 32'h0008_0000 + 32'(slot) * 32'd4;
        endfunction

        always @(posedge CLK) begin
                cycles <= cycles + 1;
                if (cycles >= MAX_CYCLES) begin
                        stop_on_error($sformatf("Timeout after %0d cycles", cycles));
                end
        end

        always @(negedge CLK) begin
                if (!started) begin
                        assert (!dp_rsp.dhit && !dp_rsp.flushed && !mem_req.ren && !mem_req.wen)
                        else stop_on_error("Cache outputs active before the first request");
                end
                if (dp_rsp.flushed) begin
                        assert (!mem_req.wen)
                        else stop_on_error("Memory write while flushed is high");
                end
                if (flushed_seen) begin
                        assert (dp_rsp.flushed)
                        else stop_on_error("flushed dropped before reset");
                end
                flushed_seen <= flushed_seen || (dp_rsp.flushed === 1'b1);
        end

        // Drive on the rising edge, sample at the falling edge until dhit
        task automatic access(input logic wr, input logic atom, input int slot,
                              input word_t data, output word_t load);
                dp_req_t req;
                req = '0;
                req.ren = !wr;
                req.wen = wr;
                req.atomic = atom;
                req.addr = slot_addr(slot);
                req.store = data;
                @(posedge CLK);
                dp_req <= req;
                started <= 1'b1;
                do begin
                        @(negedge CLK);
                end while (!dp_rsp.dhit);
                load = dp_rsp.load;
        endtask

        task automatic load_and_check(input int slot, input logic ll);
                word_t got;
                access(1'b0, ll, slot, '0, got);
                check_word("dp_rsp.load", ref_mem[slot], got);
                if (ll) begin
                        link_valid = 1'b1;
                        link_slot = slot;
                end
                if ($urandom_range(3, 0) == 0) begin
                        // A request held one more cycle must hit with no memory traffic
                        @(posedge CLK);
                        @(negedge CLK);
                        assert (dp_rsp.dhit && !mem_req.ren && !mem_req.wen)
                        else stop_on_error("Repeated load did not hit in the same cycle");
                        check_word("dp_rsp.load", ref_mem[slot], dp_rsp.load);
                end
        endtask

        task automatic store_word(input int slot, input word_t data);
                word_t got;
                access(1'b1, 1'b0, slot, data, got);
                ref_mem[slot] = data;
                if (link_valid && (link_slot == slot)) begin
                        link_valid = 1'b0;
                end
        endtask

        task automatic store_conditional(input int slot, input word_t data);
                word_t got;
                logic  expect_ok;
                expect_ok = link_valid && (link_slot == slot);
                access(1'b1, 1'b1, slot, data, got);
                check_word("dp_rsp.load", 32'(expect_ok), got);
                if (expect_ok) begin
                        ref_mem[slot] = data;
                end
                link_valid = 1'b0;
        endtask

        task automatic run_random_op();
                int    kind;
                int    slot;
                word_t data;
                kind = $urandom_range(9, 0);
                slot = $urandom_range(N_SLOTS - 1, 0);
                data = $urandom;
                if (kind < 4) begin
                        load_and_check(slot, 1'b0);
                end else if (kind < 7) begin
                        store_word(slot, data);
                end else if (kind < 9) begin
                        // LL, sometimes a store in between, then one or two SCs
                        load_and_check(slot, 1'b1);
                        if ($urandom_range(3, 0) == 0) begin
                                store_word(slot, ~data);
                        end
                        store_conditional(slot, data);
                        if ($urandom_range(3, 0) == 0) begin
                                store_conditional(slot, data ^ 32'h1);
                        end
                end else begin
                        store_conditional(slot, data);
                end
        endtask

        initial begin
                dp_req_t halt_req;
                void'($urandom(32'he8ff_cddc));
                nRST = 1'b0;
                dp_req = '0;
                started = 1'b0;
                flushed_seen = 1'b0;
                link_valid = 1'b0;
                link_slot = 0;
                peek_addr = '0;
                for (int i = 0; i < N_SLOTS; i++) begin
                        peek_addr = slot_addr(i);
                        #1;
                        ref_mem[i] = peek_data;
                end
                repeat (8) @(posedge CLK);
                nRST <= 1'b1;

                for (int n = 0; n < N_OPS; n++) begin
                        run_random_op();
                end

                halt_req = '0;
                halt_req.halt = 1'b1;
                @(posedge CLK);
                dp_req <= halt_req;
                do begin
                        @(negedge CLK);
                end while (!dp_rsp.flushed);
                repeat (4) @(negedge CLK);

                // Memory now holds every dirty word
                for (int i = 0; i < N_SLOTS; i++) begin
                        peek_addr = slot_addr(i);
                        #1;
                        check_word($sformatf("memory[%h]", slot_addr(i)), ref_mem[i], peek_data);
                end

                $display("Regression passed");
                $finish;
        end

endmodule

`default_nettype wire

/* test/mem_model.sv */
`include "dcache_consts.svh"
`default_nettype none

module mem_model
        import mem_bus_pkg::*;
(
        input  wire logic     CLK,
        input  wire logic     nRST,
        input  wire mem_req_t mem_req,
        output word_t         dload,
        output logic          dwait,
        input  wire word_t    peek_addr,
        output word_t         peek_data
);

        timeunit 1ns;
        timeprecision 100ps;

        // Only written words are stored, the rest read the fill pattern
        word_t      words [word_t];
        logic [1:0] stall;

        function automatic word_t fill_word(input word_t a);
                return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a3c_0f96;
        endfunction

        function automatic word_t read_word(input word_t a);
                if (words.exists(a)) begin
                        return words[a];
                end
                return fill_word(a);
        endfunction

        always_comb begin
                dload = read_word(mem_req.addr);
                peek_data = read_word(peek_addr);
        end

        assign dwait = (mem_req.ren || mem_req.wen) && (stall != 2'd0);

        // Word moves when dwait is low, then a fresh stall of 0 to 3 cycles
        always @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        stall <= 2'd0;
                end else if (mem_req.ren || mem_req.wen) begin
                        if (stall != 2'd0) begin
                                stall <= stall - 2'd1;
                        end else begin
                                if (mem_req.wen) begin
                                        words[mem_req.addr] = mem_req.store;
                                end
                                stall <= 2'($urandom_range(3, 0));
                        end
                end
        end

endmodule

`default_nettype wire

/* design/dcache.sv */
`include "dcache_consts.svh"
`default_nettype none

module dcache
        import cache_types_pkg::*, mem_bus_pkg::*;
(
        input  wire logic               CLK,
        input  wire logic               nRST,
        input  wire dp_req_t            dp_req,
        output dp_rsp_t                 dp_rsp,
        output mem_req_t                mem_req,
        input  wire mem_bus_pkg::word_t dload,
        input  wire logic               dwait
);

        dcache_addr_u lookup_addr;
        set_view_t    set_view;
        lookup_t      lookup;
        array_wr_t    arr_wr;
        logic         ll_set;
        logic         sc_try;
        logic         store_done;
        logic         sc_ok;

        dcache_ctrl u_ctrl (
                .CLK         (CLK),
                .nRST        (nRST),
                .dp_req      (dp_req),
                .dp_rsp      (dp_rsp),
                .mem_req     (mem_req),
                .dload       (dload),
                .dwait       (dwait),
                .lookup_addr (lookup_addr),
                .set_view    (set_view),
                .lookup      (lookup),
                .arr_wr      (arr_wr),
                .ll_set      (ll_set),
                .sc_try      (sc_try),
                .store_done  (store_done),
                .sc_ok       (sc_ok)
        );

        dcache_array u_array (
                .CLK         (CLK),
                .nRST        (nRST),
                .lookup_addr (lookup_addr),
                .arr_wr      (arr_wr),
                .set_view    (set_view),
                .lookup      (lookup)
        );

        llsc_reservation u_llsc (
                .CLK         (CLK),
                .nRST        (nRST),
                .addr        (dp_req.addr),
                .ll_set      (ll_set),
                .sc_try      (sc_try),
                .store_done  (store_done),
                .sc_ok       (sc_ok)
        );

endmodule

`default_nettype wire

/* design/dcache_ctrl.sv */
`include "dcache_consts.svh"
`default_nettype none

module dcache_ctrl
        import cache_types_pkg::*, mem_bus_pkg::*;
(
        input  wire logic               CLK,
        input  wire logic               nRST,
        input  wire dp_req_t            dp_req,
        output dp_rsp_t                 dp_rsp,
        output mem_req_t                mem_req,
        input  wire mem_bus_pkg::word_t dload,
        input  wire logic               dwait,
        output dcache_addr_u            lookup_addr,
        input  wire set_view_t          set_view,
        input  wire lookup_t            lookup,
        output array_wr_t               arr_wr,
        output logic                    ll_set,
        output logic                    sc_try,
        output logic                    store_done,
        input  wire logic               sc_ok
);

        dc_state_e            state;
        dc_state_e            next_state;
        // {set, way} of the frame being flushed
        logic [`DC_IDX_W:0]   flush_ptr;
        logic [`DC_IDX_W:0]   next_flush_ptr;

        logic                 flushing;
        logic                 fill_phase;
        logic                 second_word;
        logic                 sel_way;
        dcache_frame_t        sel_frame;
        dcache_addr_u         mem_addr;

        assign flushing = (state == st_flush_scan) || (state == st_flush_wb0) ||
                          (state == st_flush_wb1);
        assign fill_phase = (state == st_fill0) || (state == st_fill1);
        assign second_word = (state == st_wb1) || (state == st_fill1) ||
                             (state == st_flush_wb1);

        // Frame moved to or from memory
        assign sel_way = flushing ? flush_ptr[0] : lookup.victim_way;
        assign sel_frame = set_view.frame[sel_way];

        always_comb begin
                lookup_addr.raw = dp_req.addr;
                if (flushing) begin
                        lookup_addr.f.idx = flush_ptr[`DC_IDX_W:1];
                end
        end

        always_comb begin
                mem_addr.f.tag = fill_phase ? lookup_addr.f.tag : sel_frame.tag;
                mem_addr.f.idx = lookup_addr.f.idx;
                mem_addr.f.blkoff = second_word;
                mem_addr.f.bytoff = '0;

                mem_req.ren = fill_phase;
                mem_req.wen = (state == st_wb0) || (state == st_wb1) ||
                              (state == st_flush_wb0) || (state == st_flush_wb1);
                mem_req.addr = mem_addr.raw;
                mem_req.store = sel_frame.data[second_word];
        end

        always_comb begin
                next_state = state;
                next_flush_ptr = flush_ptr;

                dp_rsp = '0;
                dp_rsp.flushed = (state == st_flushed);
                ll_set = 1'b0;
                sc_try = 1'b0;
                store_done = 1'b0;

                arr_wr = '0;
                arr_wr.way = sel_way;
                arr_wr.tag = lookup_addr.f.tag;
                arr_wr.word_sel = second_word;
                arr_wr.data = dload;

                case (state)
                st_idle: begin
                        if (dp_req.halt) begin
                                next_flush_ptr = '0;
                                next_state = st_flush_scan;
                        end else if (dp_req.wen && dp_req.atomic && !sc_ok) begin
                                // Failed SC answers at once and writes nothing
                                dp_rsp.dhit = 1'b1;
                                sc_try = 1'b1;
                        end else if ((dp_req.ren || dp_req.wen) && lookup.hit) begin
                                dp_rsp.dhit = 1'b1;
                                arr_wr.en = 1'b1;
                                arr_wr.way = lookup.hit_way;
                                arr_wr.set_lru = 1'b1;
                                arr_wr.lru = ~lookup.hit_way;
                                if (dp_req.wen) begin
                                        arr_wr.word_en = 1'b1;
                                        arr_wr.word_sel = lookup_addr.f.blkoff;
                                        arr_wr.data = dp_req.store;
                                        arr_wr.set_dirty = 1'b1;
                                        arr_wr.dirty = 1'b1;
                                        store_done = 1'b1;
                                        sc_try = dp_req.atomic;
                                        // SC success reports 1
                                        dp_rsp.load = 32'(dp_req.atomic);
                                end else begin
                                        dp_rsp.load = set_view.frame[lookup.hit_way]
                                                        .data[lookup_addr.f.blkoff];
                                        ll_set = dp_req.atomic;
                                end
                        end else if (dp_req.ren || dp_req.wen) begin
                                next_state = sel_frame.dirty ? st_wb0 : st_fill0;
                        end
                end
                st_wb0: begin
                        if (!dwait) begin
                                next_state = st_wb1;
                        end
                end
                st_wb1: begin
                        if (!dwait) begin
                                arr_wr.en = 1'b1;
                                arr_wr.set_dirty = 1'b1;
                                arr_wr.dirty = 1'b0;
                                next_state = st_fill0;
                        end
                end
                st_fill0: begin
                        // New tag goes in now, frame stays invalid until word 1
                        if (!dwait) begin
                                arr_wr.en = 1'b1;
                                arr_wr.set_tag = 1'b1;
                                arr_wr.set_valid = 1'b1;
                                arr_wr.valid = 1'b0;
                                arr_wr.word_en = 1'b1;
                                next_state = st_fill1;
                        end
                end
                st_fill1: begin
                        if (!dwait) begin
                                arr_wr.en = 1'b1;
                                arr_wr.set_valid = 1'b1;
                                arr_wr.valid = 1'b1;
                                arr_wr.word_en = 1'b1;
                                arr_wr.set_lru = 1'b1;
                                arr_wr.lru = ~sel_way;
                                next_state = st_idle;
                        end
                end
                st_flush_scan: begin
                        if (sel_frame.dirty) begin
                                next_state = st_flush_wb0;
                        end else if (&flush_ptr) begin
                                next_state = st_flushed;
                        end else begin
                                next_flush_ptr = flush_ptr + 1'b1;
                        end
                end
                st_flush_wb0: begin
                        if (!dwait) begin
                                next_state = st_flush_wb1;
                        end
                end
                st_flush_wb1: begin
                        // Rescan the same frame once it is clean
                        if (!dwait) begin
                                arr_wr.en = 1'b1;
                                arr_wr.set_dirty = 1'b1;
                                arr_wr.dirty = 1'b0;
                                next_state = st_flush_scan;
                        end
                end
                st_flushed: begin
                        next_state = st_flushed;
                end
                default: begin
                        next_state = st_idle;
                end
                endcase
        end

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        state <= st_idle;
                        flush_ptr <= '0;
                end else begin
                        state <= next_state;
                        flush_ptr <= next_flush_ptr;
                end
        end

endmodule

`default_nettype wire

/* design/dcache_array.sv */
`include "dcache_consts.svh"
`default_nettype none

module dcache_array
        import cache_types_pkg::*;
(
        input  wire logic         CLK,
        input  wire logic         nRST,
        input  wire dcache_addr_u lookup_addr,
        input  wire array_wr_t    arr_wr,
        output set_view_t         set_view,
        output lookup_t           lookup
);

        // Status bits
        logic [`DC_SETS-1:0][`DC_WAYS-1:0] valid_q;
        logic [`DC_SETS-1:0][`DC_WAYS-1:0] dirty_q;
        logic [`DC_SETS-1:0]               lru_q;

        // Tag and data storage
        logic [`DC_TAG_W-1:0]      tag_mem  [`DC_SETS][`DC_WAYS];
        word_t [`DC_BLK_WORDS-1:0] data_mem [`DC_SETS][`DC_WAYS];

        logic [`DC_IDX_W-1:0] idx;
        logic [`DC_WAYS-1:0]  match;

        assign idx = lookup_addr.f.idx;

        always_comb begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                        set_view.frame[w].valid = valid_q[idx][w];
                        set_view.frame[w].dirty = dirty_q[idx][w];
                        set_view.frame[w].tag = tag_mem[idx][w];
                        set_view.frame[w].data = data_mem[idx][w];
                        match[w] = valid_q[idx][w] && (tag_mem[idx][w] == lookup_addr.f.tag);
                end
                set_view.lru = lru_q[idx];
        end

        assign lookup.hit = |match;
        assign lookup.hit_way = match[1];
        // LRU bit names the way to replace
        assign lookup.victim_way = set_view.lru;

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        valid_q <= '0;
                        dirty_q <= '0;
                        lru_q <= '0;
                end else if (arr_wr.en) begin
                        if (arr_wr.set_valid) begin
                                valid_q[idx][arr_wr.way] <= arr_wr.valid;
                        end
                        if (arr_wr.set_dirty) begin
                                dirty_q[idx][arr_wr.way] <= arr_wr.dirty;
                        end
                        if (arr_wr.set_lru) begin
                                lru_q[idx] <= arr_wr.lru;
                        end
                end
        end

        always_ff @(posedge CLK) begin
                if (arr_wr.en) begin
                        if (arr_wr.set_tag) begin
                                tag_mem[idx][arr_wr.way] <= arr_wr.tag;
                        end
                        if (arr_wr.word_en) begin
                                data_mem[idx][arr_wr.way][arr_wr.word_sel] <= arr_wr.data;
                        end
                end
        end

endmodule

`default_nettype wire

/* design/llsc_reservation.sv */
`include "dcache_consts.svh"
`default_nettype none

module llsc_reservation
        import cache_types_pkg::*;
(
        input  wire logic  CLK,
        input  wire logic  nRST,
        input  wire word_t addr,
        input  wire logic  ll_set,
        input  wire logic  sc_try,
        input  wire logic  store_done,
        output logic       sc_ok
);

        word_t link_addr;
        logic  link_valid;

        assign sc_ok = link_valid && (link_addr == addr);

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        link_valid <= 1'b0;
                end else if (ll_set) begin
                        link_valid <= 1'b1;
                end else if (sc_try || (store_done && (addr == link_addr))) begin
                        // Any SC or a store to the linked word ends it
                        link_valid <= 1'b0;
                end
        end

        always_ff @(posedge CLK) begin
                if (ll_set) begin
                        link_addr <= addr;
                end
        end

endmodule

`default_nettype wire

/* design/mem_bus_pkg.sv */
`include "dcache_consts.svh"
`default_nettype none

package mem_bus_pkg;

        typedef logic [`DC_WORD_W-1:0] word_t;

        // Processor to cache, held until dhit
        typedef struct packed {
                logic  ren;
                logic  wen;
                logic  atomic;
                logic  halt;
                word_t addr;
                word_t store;
        } dp_req_t;

        typedef struct packed {
                logic  dhit;
                word_t load;
                logic  flushed;
        } dp_rsp_t;

        // Cache to memory, held until dwait drops
        typedef struct packed {
                logic  ren;
                logic  wen;
                word_t addr;
                word_t store;
        } mem_req_t;

endpackage

`default_nettype wire

/* design/cache_types_pkg.sv */
`include "dcache_consts.svh"
`default_nettype none

package cache_types_pkg;

        typedef logic [`DC_WORD_W-1:0] word_t;

        // tag | index | block offset | byte offset
        typedef struct packed {
                logic [`DC_TAG_W-1:0]      tag;
                logic [`DC_IDX_W-1:0]      idx;
                logic [`DC_BLK_OFF_W-1:0]  blkoff;
                logic [`DC_BYTE_OFF_W-1:0] bytoff;
        } dcache_addr_fields_t;

        typedef union packed {
                word_t               raw;
                dcache_addr_fields_t f;
        } dcache_addr_u;

        typedef struct packed {
                logic                          valid;
                logic                          dirty;
                logic [`DC_TAG_W-1:0]          tag;
                word_t [`DC_BLK_WORDS-1:0]     data;
        } dcache_frame_t;

        // Both ways of the addressed set
        typedef struct packed {
                dcache_frame_t [`DC_WAYS-1:0] frame;
                logic                         lru;
        } set_view_t;

        typedef struct packed {
                logic hit;
                logic hit_way;
                logic victim_way;
        } lookup_t;

        typedef struct packed {
                logic                 en;
                logic                 way;
                logic                 set_tag;
                logic [`DC_TAG_W-1:0] tag;
                logic                 set_valid;
                logic                 valid;
                logic                 set_dirty;
                logic                 dirty;
                logic                 word_en;
                logic                 word_sel;
                word_t                data;
                logic                 set_lru;
                logic                 lru;
        } array_wr_t;

        typedef enum logic [3:0] {
                st_idle       = 4'd0,
                st_wb0        = 4'd1,
                st_wb1        = 4'd2,
                st_fill0      = 4'd3,
                st_fill1      = 4'd4,
                st_flush_scan = 4'd5,
                st_flush_wb0  = 4'd6,
                st_flush_wb1  = 4'd7,
                st_flushed    = 4'd8
        } dc_state_e;

endpackage

`default_nettype wire

/* design/dcache_consts.svh */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

`default_nettype none

// Word and address geometry
`define DC_WORD_W       32
`define DC_TAG_W        26
`define DC_IDX_W        3
`define DC_BLK_OFF_W    1
`define DC_BYTE_OFF_W   2

// Cache organisation
`define DC_SETS         8
`define DC_WAYS         2
`define DC_BLK_WORDS    2

`default_nettype wire

`endif
